// ==== list.f ====
rtl/pw_pkg.sv
rtl/pw_weight_store.sv
rtl/pw_group_filler.sv
rtl/pw_cache_lane.sv
rtl/pw_lane_select.sv
rtl/pw_param_cache.sv
test/pw_param_cache_sva.sv
test/pw_param_cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the result.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module pw_param_cache_tb \
    -f list.f \
    -o sim

./obj_dir/sim | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi

// ==== test/pw_param_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_param_cache_tb;

    localparam int CLK_PERIOD    = 10;
    localparam int PARAM_WRITES  = 200;
    localparam int PARAM_READS   = 120;
    localparam int WEIGHT_WRITES = 300;
    localparam int GROUP_LOADS   = 6;
    localparam int MISS_READS    = 40;
    localparam int HOLD_WRITES   = 50;
    localparam int BAD_WRITES    = 40;
    localparam int FILL_MAX      = pw_pkg::PW_GROUP * pw_pkg::MAX_IN_CH + 4;
    localparam int GROUP_CYCLES  = FILL_MAX + pw_pkg::PW_GROUP * pw_pkg::MAX_IN_CH + 4;
    localparam int TEST_CYCLES   =
        (pw_pkg::WEIGHT_DEPTH + 5 * pw_pkg::TOTAL_OUT_CH)
        + (PARAM_WRITES + PARAM_READS)
        + (WEIGHT_WRITES + GROUP_LOADS * GROUP_CYCLES)
        + GROUP_CYCLES + (GROUP_CYCLES + MISS_READS)
        + (HOLD_WRITES + 2 * GROUP_CYCLES)
        + (6 * BAD_WRITES + pw_pkg::TOTAL_OUT_CH + GROUP_LOADS * GROUP_CYCLES);
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 10 + 200;

    logic                      clk;
    logic                      rst_n;
    pw_pkg::wr_cmd_t           wr;
    pw_pkg::grp_req_t          grp;
    logic                      grp_ready;
    pw_pkg::pw_sel_t           sel;
    logic [pw_pkg::DATA_W-1:0] weight_out;
    pw_pkg::quant_params_t     params;

    // Reference copy of every bank.
    logic [pw_pkg::DATA_W-1:0]  m_weight   [pw_pkg::WEIGHT_DEPTH];
    logic [pw_pkg::ACC_W-1:0]   m_bias_acc [pw_pkg::TOTAL_OUT_CH];
    logic [pw_pkg::MUL_W-1:0]   m_mul      [pw_pkg::TOTAL_OUT_CH];
    logic [pw_pkg::BIAS_W-1:0]  m_bias_rq  [pw_pkg::TOTAL_OUT_CH];
    logic [pw_pkg::SHIFT_W-1:0] m_shift    [pw_pkg::TOTAL_OUT_CH];
    logic [pw_pkg::DATA_W-1:0]  m_relu6    [pw_pkg::TOTAL_OUT_CH];

    int unsigned rng_state   = 92707;
    int          checks      = 0;
    int          errors      = 0;
    int          test_checks = 0;
    int          test_errors = 0;

    pw_param_cache dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr),
        .grp       (grp),
        .grp_ready (grp_ready),
        .sel       (sel),
        .weight    (weight_out),
        .params    (params)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        int unsigned r;
        r = lcg_next();
        return int'((r >> 8) % unsigned'(n));  // Low LCG bits repeat quickly.
    endfunction

    function automatic logic [31:0] rand_word();
        int unsigned hi;
        int unsigned lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic void model_write(input pw_pkg::param_bank_e bank, input int addr,
                                        input logic [31:0] data);
        if (bank == pw_pkg::weight) begin
            if (addr < pw_pkg::WEIGHT_DEPTH) begin
                m_weight[addr] = data[pw_pkg::DATA_W-1:0];
            end
        end else if (addr < pw_pkg::TOTAL_OUT_CH) begin
            case (bank)
                pw_pkg::bias_acc: m_bias_acc[addr] = data[pw_pkg::ACC_W-1:0];
                pw_pkg::mul:      m_mul[addr] = data[pw_pkg::MUL_W-1:0];
                pw_pkg::bias_rq:  m_bias_rq[addr] = data[pw_pkg::BIAS_W-1:0];
                pw_pkg::shift:    m_shift[addr] = data[pw_pkg::SHIFT_W-1:0];
                default:          m_relu6[addr] = data[pw_pkg::DATA_W-1:0];
            endcase
        end
    endfunction

    function automatic pw_pkg::quant_params_t expected_params(input int layer, input int oc);
        pw_pkg::quant_params_t p;
        int                    a;
        a = pw_pkg::LAYER_CH_BASE[layer] + oc;
        p.bias_acc  = m_bias_acc[a];
        p.mul       = m_mul[a];
        p.bias_rq   = m_bias_rq[a];
        p.shift     = m_shift[a];
        p.relu6_max = m_relu6[a];
        return p;
    endfunction

    // Channels past out_c are zero in the cache.
    function automatic logic [7:0] expected_weight(input int layer, input int oc, input int ic);
        if (oc >= pw_pkg::LAYER_OUT_C[layer]) begin
            return '0;
        end
        return m_weight[pw_pkg::LAYER_W_BASE[layer] + oc * pw_pkg::LAYER_IN_C[layer] + ic];
    endfunction

    task automatic check_equal(input string what, input logic [127:0] got,
                               input logic [127:0] expected);
        checks++;
        test_checks++;
        assert (got === expected) else begin
            $display("[ERROR] %0t ns: %s: got %0h, expected %0h", $time, what, got, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic write_word(input pw_pkg::param_bank_e bank, input int addr,
                              input logic [31:0] data);
        @(posedge clk);
        #1;
        wr.en   = 1'b1;
        wr.bank = bank;
        wr.addr = pw_pkg::WR_ADDR_W'(addr);
        wr.data = data;
        model_write(bank, addr, data);
    endtask

    task automatic release_writes();
        @(posedge clk);
        #1;
        wr.en = 1'b0;
    endtask

    task automatic read_params(input int layer, input int oc);
        @(posedge clk);
        #1;
        sel.layer  = 8'(layer);
        sel.out_ch = 8'(oc);
        sel.in_ch  = '0;
        #4;
        check_equal($sformatf("params L%0d oc %0d", layer, oc), 128'(params),
                    128'(expected_params(layer, oc)));
    endtask

    task automatic read_weight(input int layer, input int oc, input int ic,
                               input logic [7:0] expected);
        @(posedge clk);
        #1;
        sel.layer  = 8'(layer);
        sel.out_ch = 8'(oc);
        sel.in_ch  = 8'(ic);
        #4;
        check_equal($sformatf("weight L%0d oc %0d ic %0d", layer, oc, ic),
                    128'(weight_out), 128'(expected));
    endtask

    task automatic request_group(input int layer, input int group);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        grp.req   = 1'b1;
        grp.layer = 8'(layer);
        grp.group = 8'(group);
        #4;
        while (!grp_ready && waited < FILL_MAX) begin
            @(posedge clk);
            #5;
            waited++;
        end
        assert (grp_ready) else begin
            $display("Request for layer %0d group %0d never saw grp_ready.", layer, group);
            errors++;
            test_errors++;
        end
        @(posedge clk);
        #1;
        grp.req = 1'b0;
    endtask

    task automatic verify_group(input int layer, input int group);
        int oc;
        for (int lane = 0; lane < pw_pkg::PW_GROUP; lane++) begin
            oc = group * pw_pkg::PW_GROUP + lane;
            for (int ic = 0; ic < pw_pkg::LAYER_IN_C[layer]; ic++) begin
                read_weight(layer, oc, ic, expected_weight(layer, oc, ic));
            end
        end
    endtask

    task automatic load_random_groups(input int n);
        int layer;
        int group;
        for (int i = 0; i < n; i++) begin
            layer = rand_below(pw_pkg::NUM_LAYERS);
            group = rand_below(pw_pkg::LAYER_OUT_C[layer] / pw_pkg::PW_GROUP);
            request_group(layer, group);
            verify_group(layer, group);
        end
    endtask

    task automatic fill_all_banks();
        for (int a = 0; a < pw_pkg::WEIGHT_DEPTH; a++) begin
            write_word(pw_pkg::weight, a, rand_word());
        end
        for (int b = 1; b <= 5; b++) begin
            for (int a = 0; a < pw_pkg::TOTAL_OUT_CH; a++) begin
                write_word(pw_pkg::param_bank_e'(b), a, rand_word());
            end
        end
        release_writes();
    endtask

    task automatic param_readback();
        int layer;
        for (int i = 0; i < PARAM_WRITES; i++) begin
            write_word(pw_pkg::param_bank_e'(1 + rand_below(5)),
                       rand_below(pw_pkg::TOTAL_OUT_CH), rand_word());
        end
        release_writes();
        for (int i = 0; i < PARAM_READS; i++) begin
            layer = rand_below(pw_pkg::NUM_LAYERS);
            read_params(layer, rand_below(pw_pkg::LAYER_OUT_C[layer]));
        end
        finish_test("param_readback");
    endtask

    task automatic group_load();
        for (int i = 0; i < WEIGHT_WRITES; i++) begin
            write_word(pw_pkg::weight, rand_below(pw_pkg::WEIGHT_DEPTH), rand_word());
        end
        release_writes();
        load_random_groups(GROUP_LOADS);
        finish_test("group_load");
    endtask

    task automatic zero_fill();
        request_group(1, 4);  // Out_ch 16 to 19 of a 16 channel layer.
        for (int lane = 0; lane < pw_pkg::PW_GROUP; lane++) begin
            for (int ic = 0; ic < pw_pkg::LAYER_IN_C[1]; ic++) begin
                read_weight(1, 4 * pw_pkg::PW_GROUP + lane, ic, 8'd0);
            end
        end
        finish_test("zero_fill");
    endtask

    task automatic miss_reads();
        int         layer;
        int         oc;
        int         ic;
        logic [7:0] expected;
        request_group(2, 3);
        @(posedge clk);
        #1;
        grp.layer = 8'd1;
        grp.group = 8'd3;
        #4;
        check_equal("grp_ready for a mismatched request", 128'(grp_ready), 128'(0));
        for (int i = 0; i < MISS_READS; i++) begin
            layer = rand_below(pw_pkg::NUM_LAYERS);
            oc    = rand_below(pw_pkg::LAYER_OUT_C[layer]);
            ic    = rand_below(pw_pkg::LAYER_IN_C[layer]);
            if (layer == 2 && oc / pw_pkg::PW_GROUP == 3) begin
                expected = expected_weight(layer, oc, ic);
            end else begin
                expected = '0;
            end
            read_weight(layer, oc, ic, expected);
        end
        finish_test("miss_reads");
    endtask

    task automatic cache_hold();
        int group;
        @(posedge clk);
        #1;
        grp.req   = 1'b1;
        grp.layer = 8'd2;
        grp.group = 8'd3;
        #4;
        check_equal("grp_ready for the cached group", 128'(grp_ready), 128'(1));
        @(posedge clk);
        #1;
        grp.req = 1'b0;
        for (int i = 0; i < HOLD_WRITES; i++) begin
            write_word(pw_pkg::weight, pw_pkg::LAYER_W_BASE[3]
                       + rand_below(pw_pkg::LAYER_OUT_C[3] * pw_pkg::LAYER_IN_C[3]), rand_word());
        end
        release_writes();
        group = rand_below(pw_pkg::LAYER_OUT_C[3] / pw_pkg::PW_GROUP);
        @(posedge clk);
        #1;
        grp.req   = 1'b1;
        grp.layer = 8'd3;
        grp.group = 8'(group);
        #4;
        check_equal("grp_ready before the new group loads", 128'(grp_ready), 128'(0));
        request_group(3, group);
        verify_group(3, group);
        finish_test("cache_hold");
    endtask

    task automatic ignored_writes();
        int depth;
        for (int b = 0; b < 6; b++) begin
            depth = (b == 0) ? pw_pkg::WEIGHT_DEPTH : pw_pkg::TOTAL_OUT_CH;
            for (int i = 0; i < BAD_WRITES; i++) begin
                write_word(pw_pkg::param_bank_e'(b),
                           depth + rand_below((1 << pw_pkg::WR_ADDR_W) - depth), rand_word());
            end
        end
        release_writes();
        for (int layer = 0; layer < pw_pkg::NUM_LAYERS; layer++) begin
            for (int oc = 0; oc < pw_pkg::LAYER_OUT_C[layer]; oc++) begin
                read_params(layer, oc);
            end
        end
        load_random_groups(GROUP_LOADS);
        finish_test("ignored_writes");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles.", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        wr    = '0;
        grp   = '0;
        sel   = '0;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        #4;
        check_equal("grp_ready after reset", 128'(grp_ready), 128'(0));
        finish_test("reset");
        fill_all_banks();
        param_readback();
        group_load();
        zero_fill();
        miss_reads();
        cache_hold();
        ignored_writes();
        @(posedge clk);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/pw_param_cache_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_param_cache_sva (
    input logic                clk,
    input logic                rst_n,
    input pw_pkg::grp_req_t    grp,
    input pw_pkg::cache_tag_t  tag,
    input pw_pkg::fill_beat_t  beat,
    input logic                grp_ready
);

    // No ready while beats are still landing.
    ready_low_in_fill: assert property (
        @(posedge clk) disable iff (!rst_n) beat.valid |-> !grp_ready
    ) else $error("grp_ready high during a fill");

    ready_low_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !grp_ready
    ) else $error("grp_ready high in the first cycle after reset");

    // A held hit must leave the tag alone.
    tag_stable_on_hit: assert property (
        @(posedge clk) disable iff (!rst_n) (grp_ready && $stable(grp)) |=> $stable(tag)
    ) else $error("tag changed while the cached group was ready");

endmodule

bind pw_group_filler pw_param_cache_sva sva0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .grp       (grp),
    .tag       (tag),
    .beat      (beat),
    .grp_ready (grp_ready)
);

`default_nettype wire

// ==== rtl/pw_param_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_param_cache (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pw_pkg::wr_cmd_t           wr,
    input  pw_pkg::grp_req_t          grp,
    output logic                      grp_ready,
    input  pw_pkg::pw_sel_t           sel,
    output logic [pw_pkg::DATA_W-1:0] weight,
    output pw_pkg::quant_params_t     params
);

    logic [pw_pkg::WR_ADDR_W-1:0]                     src_addr;
    logic [pw_pkg::DATA_W-1:0]                        src_data;
    pw_pkg::fill_beat_t                               beat;
    pw_pkg::cache_tag_t                               tag;
    logic [pw_pkg::PW_GROUP-1:0][pw_pkg::DATA_W-1:0]  lane_data;
    logic [pw_pkg::DIM_W-1:0]                         lane_ic;

    pw_weight_store store0 (
        .clk      (clk),
        .wr       (wr),
        .src_addr (src_addr),
        .src_data (src_data),
        .sel      (sel),
        .params   (params)
    );

    pw_group_filler filler0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .grp       (grp),
        .src_addr  (src_addr),
        .src_data  (src_data),
        .beat      (beat),
        .tag       (tag),
        .grp_ready (grp_ready)
    );

    for (genvar i = 0; i < pw_pkg::PW_GROUP; i++) begin : gen_lane
        pw_pkg::fill_beat_t lane_beat;

        always_comb begin
            lane_beat       = beat;
            lane_beat.valid = beat.valid && (int'(beat.lane) == i);  // Own lane only.
        end

        pw_cache_lane lane0 (
            .clk     (clk),
            .beat    (lane_beat),
            .rd_ic   (lane_ic),
            .rd_data (lane_data[i])
        );
    end

    pw_lane_select select0 (
        .sel       (sel),
        .tag       (tag),
        .lane_data (lane_data),
        .lane_ic   (lane_ic),
        .weight    (weight)
    );

endmodule

`default_nettype wire

// ==== rtl/pw_lane_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_lane_select (
    input  pw_pkg::pw_sel_t                                  sel,
    input  pw_pkg::cache_tag_t                               tag,
    input  logic [pw_pkg::PW_GROUP-1:0][pw_pkg::DATA_W-1:0]  lane_data,
    output logic [pw_pkg::DIM_W-1:0]                         lane_ic,
    output logic [pw_pkg::DATA_W-1:0]                        weight
);

    logic [pw_pkg::DIM_W-1:0]  sel_group;
    logic [pw_pkg::LANE_W-1:0] sel_lane;
    logic                      ic_ok;
    logic                      hit;

    // out_ch splits into group and lane bits.
    assign sel_group = {{pw_pkg::LANE_W{1'b0}}, sel.out_ch[pw_pkg::DIM_W-1:pw_pkg::LANE_W]};
    assign sel_lane  = sel.out_ch[pw_pkg::LANE_W-1:0];

    assign ic_ok   = sel.in_ch < pw_pkg::MAX_IN_CH;
    assign lane_ic = ic_ok ? sel.in_ch : '0;

    assign hit = tag.valid && (tag.layer == sel.layer) && (tag.group == sel_group);

    assign weight = (hit && ic_ok) ? lane_data[sel_lane] : '0;  // Miss reads as zero.

endmodule

`default_nettype wire

// ==== rtl/pw_cache_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_cache_lane (
    input  logic                      clk,
    input  pw_pkg::fill_beat_t        beat,
    input  logic [pw_pkg::DIM_W-1:0]  rd_ic,
    output logic [pw_pkg::DATA_W-1:0] rd_data
);

    logic [pw_pkg::DATA_W-1:0] mem [pw_pkg::MAX_IN_CH];
    logic                      wr_ok;

    // Beat valid already qualified by lane number.
    assign wr_ok = beat.valid && (beat.ic < pw_pkg::MAX_IN_CH);

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[beat.ic[pw_pkg::IC_W-1:0]] <= beat.data;
        end
    end

    assign rd_data = mem[rd_ic[pw_pkg::IC_W-1:0]];

endmodule

`default_nettype wire

// ==== rtl/pw_group_filler.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_group_filler (
    input  logic                         clk,
    input  logic                         rst_n,
    input  pw_pkg::grp_req_t             grp,
    output logic [pw_pkg::WR_ADDR_W-1:0] src_addr,
    input  logic [pw_pkg::DATA_W-1:0]    src_data,
    output pw_pkg::fill_beat_t           beat,
    output pw_pkg::cache_tag_t           tag,
    output logic                         grp_ready
);

    pw_pkg::fill_state_e state;

    logic [pw_pkg::DIM_W-1:0]              ic_cnt;
    logic [pw_pkg::LANE_W:0]               lane_cnt;  // Top bit set once all lanes issued.
    logic [pw_pkg::DIM_W-1:0]              in_c;
    logic [pw_pkg::DIM_W-1:0]              last_ic;
    logic [pw_pkg::DIM_W+pw_pkg::LANE_W-1:0] oc_glb;
    logic                                  issue;
    logic                                  real_ch;
    logic                                  last_issue;
    logic                                  tag_hit;
    logic                                  accept;

    logic                      beat_vld_q;
    logic                      beat_last_q;
    logic                      beat_zero_q;
    logic [pw_pkg::LANE_W-1:0] beat_lane_q;
    logic [pw_pkg::DIM_W-1:0]  beat_ic_q;

    assign in_c    = pw_pkg::in_c_of(tag.layer);
    assign last_ic = (in_c == '0) ? '0 : in_c - 1'b1;
    assign oc_glb  = {tag.group, lane_cnt[pw_pkg::LANE_W-1:0]};  // group * PW_GROUP + lane.
    assign issue   = (state == pw_pkg::fill) && !lane_cnt[pw_pkg::LANE_W];
    assign real_ch = oc_glb < {{pw_pkg::LANE_W{1'b0}}, pw_pkg::out_c_of(tag.layer)};

    assign last_issue = issue && (ic_cnt == last_ic) && (&lane_cnt[pw_pkg::LANE_W-1:0]);

    // Channels past out_c read nothing.
    assign src_addr = (issue && real_ch) ? pw_pkg::w_addr(tag.layer, oc_glb, ic_cnt) : '0;

    assign tag_hit   = tag.valid && (tag.layer == grp.layer) && (tag.group == grp.group);
    assign accept    = grp.req && (state != pw_pkg::fill) && !tag_hit;
    assign grp_ready = (state == pw_pkg::hold) && tag_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= pw_pkg::idle;
            tag      <= '0;
            ic_cnt   <= '0;
            lane_cnt <= '0;
        end else if (accept) begin
            state     <= pw_pkg::fill;
            tag.valid <= 1'b0;
            tag.layer <= grp.layer;
            tag.group <= grp.group;
            ic_cnt    <= '0;
            lane_cnt  <= '0;
        end else if (state == pw_pkg::fill) begin
            if (issue) begin
                if (ic_cnt == last_ic) begin
                    ic_cnt   <= '0;
                    lane_cnt <= lane_cnt + 1'b1;
                end else begin
                    ic_cnt <= ic_cnt + 1'b1;
                end
            end
            if (beat_last_q) begin
                state     <= pw_pkg::hold;  // Last beat lands this edge.
                tag.valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_vld_q  <= 1'b0;
            beat_last_q <= 1'b0;
        end else begin
            beat_vld_q  <= issue;
            beat_last_q <= last_issue;
        end
    end

    always_ff @(posedge clk) begin
        beat_lane_q <= lane_cnt[pw_pkg::LANE_W-1:0];
        beat_ic_q   <= ic_cnt;
        beat_zero_q <= !real_ch;
    end

    always_comb begin
        beat.valid = beat_vld_q;
        beat.lane  = beat_lane_q;
        beat.ic    = beat_ic_q;
        beat.data  = beat_zero_q ? '0 : src_data;
    end

endmodule

`default_nettype wire

// ==== rtl/pw_weight_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_weight_store (
    input  logic                         clk,
    input  pw_pkg::wr_cmd_t              wr,
    input  logic [pw_pkg::WR_ADDR_W-1:0] src_addr,
    output logic [pw_pkg::DATA_W-1:0]    src_data,
    input  pw_pkg::pw_sel_t              sel,
    output pw_pkg::quant_params_t        params
);

    logic [pw_pkg::DATA_W-1:0]  weight_mem   [pw_pkg::WEIGHT_DEPTH];
    logic [pw_pkg::ACC_W-1:0]   bias_acc_mem [pw_pkg::TOTAL_OUT_CH];
    logic [pw_pkg::MUL_W-1:0]   mul_mem      [pw_pkg::TOTAL_OUT_CH];
    logic [pw_pkg::BIAS_W-1:0]  bias_rq_mem  [pw_pkg::TOTAL_OUT_CH];
    logic [pw_pkg::SHIFT_W-1:0] shift_mem    [pw_pkg::TOTAL_OUT_CH];
    logic [pw_pkg::DATA_W-1:0]  relu6_mem    [pw_pkg::TOTAL_OUT_CH];

    logic                         w_wr_ok;
    logic                         ch_wr_ok;
    logic [pw_pkg::CH_ADDR_W-1:0] ch_wr_addr;
    logic [pw_pkg::WR_ADDR_W-1:0] ch_rd;
    logic                         ch_rd_ok;
    logic [pw_pkg::CH_ADDR_W-1:0] ch_rd_addr;

    assign w_wr_ok    = wr.en && (wr.bank == pw_pkg::weight) &&
                        (wr.addr < pw_pkg::WEIGHT_DEPTH);
    assign ch_wr_ok   = wr.en && (wr.addr < pw_pkg::TOTAL_OUT_CH);
    assign ch_wr_addr = wr.addr[pw_pkg::CH_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (w_wr_ok) begin
            weight_mem[wr.addr] <= wr.data[pw_pkg::DATA_W-1:0];
        end
    end

    // Per-channel banks share one depth check.
    always_ff @(posedge clk) begin
        if (ch_wr_ok) begin
            case (wr.bank)
                pw_pkg::bias_acc: bias_acc_mem[ch_wr_addr] <= wr.data[pw_pkg::ACC_W-1:0];
                pw_pkg::mul:      mul_mem[ch_wr_addr] <= wr.data[pw_pkg::MUL_W-1:0];
                pw_pkg::bias_rq:  bias_rq_mem[ch_wr_addr] <= wr.data[pw_pkg::BIAS_W-1:0];
                pw_pkg::shift:    shift_mem[ch_wr_addr] <= wr.data[pw_pkg::SHIFT_W-1:0];
                pw_pkg::relu6:    relu6_mem[ch_wr_addr] <= wr.data[pw_pkg::DATA_W-1:0];
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        src_data <= weight_mem[src_addr];  // Fill source, one cycle late.
    end

    assign ch_rd      = pw_pkg::ch_addr(sel.layer, sel.out_ch);
    assign ch_rd_ok   = (sel.layer < pw_pkg::NUM_LAYERS) && (ch_rd < pw_pkg::TOTAL_OUT_CH);
    assign ch_rd_addr = ch_rd[pw_pkg::CH_ADDR_W-1:0];

    always_comb begin
        params = '0;
        if (ch_rd_ok) begin
            params.bias_acc  = bias_acc_mem[ch_rd_addr];
            params.mul       = mul_mem[ch_rd_addr];
            params.bias_rq   = bias_rq_mem[ch_rd_addr];
            params.shift     = shift_mem[ch_rd_addr];
            params.relu6_max = relu6_mem[ch_rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pw_pkg.sv ====
`default_nettype none

package pw_pkg;

    localparam int DATA_W  = 8;
    localparam int MUL_W   = 16;
    localparam int BIAS_W  = 32;
    localparam int SHIFT_W = 6;
    localparam int ACC_W   = 32;
    localparam int WR_W    = 32;

    localparam int PW_GROUP   = 4;   // Power of two, lanes are split off out_ch bits.
    localparam int NUM_LAYERS = 4;
    localparam int MAX_IN_CH  = 32;

    localparam int LAYER_IN_C    [NUM_LAYERS] = '{8, 16, 16, 32};
    localparam int LAYER_OUT_C   [NUM_LAYERS] = '{16, 16, 32, 32};
    localparam int LAYER_W_BASE  [NUM_LAYERS] = '{0, 128, 384, 896};
    localparam int LAYER_CH_BASE [NUM_LAYERS] = '{0, 16, 32, 64};

    localparam int WEIGHT_DEPTH = 1920;
    localparam int TOTAL_OUT_CH = 96;
    localparam int WR_ADDR_W    = 11;
    localparam int DIM_W        = 8;

    localparam int LANE_W    = $clog2(PW_GROUP);
    localparam int LAYER_W   = $clog2(NUM_LAYERS);
    localparam int IC_W      = $clog2(MAX_IN_CH);
    localparam int CH_ADDR_W = $clog2(TOTAL_OUT_CH);

    typedef enum logic [2:0] {
        weight,
        bias_acc,
        mul,
        bias_rq,
        shift,
        relu6
    } param_bank_e;

    typedef enum logic [1:0] {
        idle,
        fill,
        hold
    } fill_state_e;

    typedef struct packed {
        logic                 en;
        param_bank_e          bank;
        logic [WR_ADDR_W-1:0] addr;
        logic [WR_W-1:0]      data;
    } wr_cmd_t;

    typedef struct packed {
        logic [DIM_W-1:0] layer;
        logic [DIM_W-1:0] out_ch;
        logic [DIM_W-1:0] in_ch;
    } pw_sel_t;

    typedef struct packed {
        logic signed [ACC_W-1:0]  bias_acc;
        logic signed [MUL_W-1:0]  mul;
        logic signed [BIAS_W-1:0] bias_rq;
        logic [SHIFT_W-1:0]       shift;
        logic signed [DATA_W-1:0] relu6_max;
    } quant_params_t;

    typedef struct packed {
        logic             valid;
        logic [DIM_W-1:0] layer;
        logic [DIM_W-1:0] group;
    } cache_tag_t;

    typedef struct packed {
        logic              valid;
        logic [LANE_W-1:0] lane;
        logic [DIM_W-1:0]  ic;
        logic [DATA_W-1:0] data;
    } fill_beat_t;

    typedef struct packed {
        logic             req;
        logic [DIM_W-1:0] layer;
        logic [DIM_W-1:0] group;
    } grp_req_t;

    function automatic logic [DIM_W-1:0] in_c_of(input logic [DIM_W-1:0] layer);
        if (layer >= NUM_LAYERS) begin
            return '0;
        end
        return DIM_W'(LAYER_IN_C[layer[LAYER_W-1:0]]);
    endfunction

    function automatic logic [DIM_W-1:0] out_c_of(input logic [DIM_W-1:0] layer);
        if (layer >= NUM_LAYERS) begin
            return '0;
        end
        return DIM_W'(LAYER_OUT_C[layer[LAYER_W-1:0]]);
    endfunction

    // Weight bank address of one (oc, ic) pair, oc kept below out_c by the caller.
    function automatic logic [WR_ADDR_W-1:0] w_addr(
        input logic [DIM_W-1:0]        layer,
        input logic [DIM_W+LANE_W-1:0] oc,
        input logic [DIM_W-1:0]        ic
    );
        if (layer >= NUM_LAYERS) begin
            return '0;
        end
        return WR_ADDR_W'(LAYER_W_BASE[layer[LAYER_W-1:0]]
                          + int'(oc) * LAYER_IN_C[layer[LAYER_W-1:0]]
                          + int'(ic));
    endfunction

    function automatic logic [WR_ADDR_W-1:0] ch_addr(
        input logic [DIM_W-1:0] layer,
        input logic [DIM_W-1:0] oc
    );
        if (layer >= NUM_LAYERS) begin
            return '0;
        end
        return WR_ADDR_W'(LAYER_CH_BASE[layer[LAYER_W-1:0]] + int'(oc));
    endfunction

endpackage

`default_nettype wire
